//--- compile.f
source/rv_pkg.sv
source/inst_decode.sv
source/reg_file.sv
source/exe_stage.sv
source/pc_unit.sv
source/core_top.sv
tb/core_top_assert.sv
tb/tb_core_top.sv

//--- Bender.yml
package:
  name: rv64_exec_slice

sources:
  - source/rv_pkg.sv
  - source/inst_decode.sv
  - source/reg_file.sv
  - source/exe_stage.sv
  - source/pc_unit.sv
  - source/core_top.sv
  - target: simulation
    files:
      - tb/core_top_assert.sv
      - tb/tb_core_top.sv

//--- tb/tb_core_top.sv
// Directed testbench for core_top; plays instruction memory and checks each retire against a model.
module tb_core_top;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_pkg::*;

  localparam word_t RESET_PC     = 64'h8000_0000;
  localparam int    CLK_PERIOD   = 4;
  localparam int    RESET_CYCLES = 4;
  localparam int    N_RANDOM     = 24;
  // Upper bound on strobe and idle cycles over all tests.
  localparam int    N_CYCLES     = N_RANDOM + 90;
  localparam int    TIMEOUT_NS   = (RESET_CYCLES + N_CYCLES) * CLK_PERIOD + 200;

  logic    clock;
  logic    rst;
  logic    inst_valid;
  inst_t   inst;
  word_t   pc;
  logic    retire_valid;
  retire_t retire;

  // Reference model state.
  word_t model_regs [32];
  word_t model_pc;
  int    checks;
  int    errors;

  core_top #(
    .RESET_PC (RESET_PC)
  ) core_top_i (
    .clock        (clock),
    .rst          (rst),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .pc           (pc),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  function automatic word_t sext12(logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic inst_t enc_i(logic [4:0] opc, logic [2:0] f3, reg_idx_t rd,
                                  reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, opc, 2'b11};
  endfunction

  // Record for a plain sequential retire; callers fill in the rest.
  function automatic retire_t base_record(inst_t word);
    retire_t r;
    r         = '0;
    r.pc      = model_pc;
    r.next_pc = model_pc + 64'd4;
    r.rd      = word[11:7];
    return r;
  endfunction

  task automatic check_retire(retire_t got, retire_t exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0d ns: %s", $time, what);
      $display("  got pc=%h next=%h rd=%0d data=%h we=%b jmp=%b ill=%b", got.pc,
               got.next_pc, got.rd, got.rd_data, got.rd_we, got.jumped, got.illegal);
      $display("  exp pc=%h next=%h rd=%0d data=%h we=%b jmp=%b ill=%b", exp.pc,
               exp.next_pc, exp.rd, exp.rd_data, exp.rd_we, exp.jumped, exp.illegal);
    end
  endtask

  task automatic check_pc(word_t got, word_t exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0d ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_valid(logic got, logic exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0d ns: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Strobe one word on a falling edge and check its retire one cycle later.
  task automatic issue(inst_t word, retire_t exp, string what);
    inst_valid = 1'b1;
    inst       = word;
    @(negedge clock);
    inst_valid = 1'b0;
    inst       = '0;
    check_valid(retire_valid, 1'b1, {what, " retire_valid"});
    check_retire(retire, exp, what);
    if (exp.rd_we) begin
      model_regs[exp.rd] = exp.rd_data;
    end
    model_pc = exp.next_pc;
    check_pc(pc, model_pc, {what, " next pc"});
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(negedge clock);
      check_valid(retire_valid, 1'b0, "retire_valid while idle");
      check_pc(pc, model_pc, "pc while idle");
    end
  endtask

  task automatic run_op_imm(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
    inst_t   word;
    retire_t exp;
    word_t   a;
    word_t   b;
    word = enc_i(OPC_OP_IMM, f3, rd, rs1, imm);
    exp  = base_record(word);
    a    = model_regs[rs1];
    b    = sext12(imm);
    case (f3)
      F3_SLTI:  exp.rd_data = {63'b0, $signed(a) < $signed(b)};
      F3_SLTIU: exp.rd_data = {63'b0, a < b};
      default:  exp.rd_data = a + b;
    endcase
    exp.rd_we = (rd != 5'd0);
    issue(word, exp, $sformatf("op_imm f3=%0d x%0d x%0d imm=%h", f3, rd, rs1, imm));
  endtask

  task automatic run_auipc(reg_idx_t rd, logic [19:0] imm);
    inst_t   word;
    retire_t exp;
    word          = {imm, rd, OPC_AUIPC, 2'b11};
    exp           = base_record(word);
    exp.rd_data   = model_pc + {{32{imm[19]}}, imm, 12'b0};
    exp.rd_we     = (rd != 5'd0);
    issue(word, exp, $sformatf("auipc x%0d imm=%h", rd, imm));
  endtask

  task automatic run_jal(reg_idx_t rd, logic [20:0] imm);
    inst_t   word;
    retire_t exp;
    word        = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL, 2'b11};
    exp         = base_record(word);
    exp.rd_data = model_pc + 64'd4;
    exp.rd_we   = (rd != 5'd0);
    exp.jumped  = 1'b1;
    exp.next_pc = model_pc + {{43{imm[20]}}, imm};
    issue(word, exp, $sformatf("jal x%0d imm=%h", rd, imm));
  endtask

  task automatic run_jalr(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
    inst_t   word;
    retire_t exp;
    word        = enc_i(OPC_JALR, 3'b000, rd, rs1, imm);
    exp         = base_record(word);
    exp.rd_data = model_pc + 64'd4;
    exp.rd_we   = (rd != 5'd0);
    exp.jumped  = 1'b1;
    exp.next_pc = model_regs[rs1] + sext12(imm);
    exp.next_pc[0] = 1'b0;
    issue(word, exp, $sformatf("jalr x%0d x%0d imm=%h", rd, rs1, imm));
  endtask

  task automatic run_branch(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2, logic [12:0] imm);
    inst_t   word;
    retire_t exp;
    word_t   a;
    word_t   b;
    logic    taken;
    word = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH, 2'b11};
    exp  = base_record(word);
    a    = model_regs[rs1];
    b    = model_regs[rs2];
    case (f3)
      F3_BEQ:  taken = (a == b);
      F3_BNE:  taken = (a != b);
      F3_BLT:  taken = ($signed(a) < $signed(b));
      F3_BGE:  taken = ($signed(a) >= $signed(b));
      F3_BLTU: taken = (a < b);
      default: taken = (a >= b);
    endcase
    exp.jumped = taken;
    if (taken) begin
      exp.next_pc = model_pc + {{51{imm[12]}}, imm};
    end
    issue(word, exp, $sformatf("branch f3=%0d x%0d x%0d", f3, rs1, rs2));
  endtask

  task automatic run_illegal(inst_t word, string what);
    retire_t exp;
    exp         = base_record(word);
    exp.illegal = 1'b1;
    issue(word, exp, {"illegal ", what});
  endtask

  task automatic test_reset();
    check_pc(pc, RESET_PC, "pc after reset");
    check_valid(retire_valid, 1'b0, "retire_valid after reset");
    idle(2);
  endtask

  task automatic test_op_imm();
    logic [2:0] f3;
    for (int r = 1; r < 8; r++) begin
      run_op_imm(F3_ADDI, reg_idx_t'(r), 5'd0, 12'($urandom));
    end
    for (int n = 0; n < N_RANDOM; n++) begin
      case ($urandom_range(2, 0))
        0:       f3 = F3_ADDI;
        1:       f3 = F3_SLTI;
        default: f3 = F3_SLTIU;
      endcase
      run_op_imm(f3, reg_idx_t'($urandom_range(31, 1)), reg_idx_t'($urandom_range(7, 0)),
                 12'($urandom));
    end
    // Read after write, then negative values through both compares.
    run_op_imm(F3_ADDI, 5'd3, 5'd0, 12'hff9);
    run_op_imm(F3_ADDI, 5'd4, 5'd3, 12'h002);
    run_op_imm(F3_SLTI, 5'd9, 5'd3, 12'hfff);
    run_op_imm(F3_SLTIU, 5'd10, 5'd3, 12'h001);
    // x0 stays zero.
    run_op_imm(F3_ADDI, 5'd0, 5'd4, 12'h123);
    run_op_imm(F3_ADDI, 5'd11, 5'd0, 12'h000);
  endtask

  task automatic test_auipc();
    run_auipc(5'd8, 20'h00001);
    run_auipc(5'd9, 20'hfffff);
    run_auipc(5'd10, 20'($urandom));
  endtask

  task automatic test_jumps();
    run_jal(5'd1, 21'd16);
    run_jal(5'd0, 21'h1ffff8);
    run_auipc(5'd11, 20'h00000);
    // Odd offsets exercise the cleared bit 0.
    run_jalr(5'd12, 5'd11, 12'd13);
    run_jalr(5'd11, 5'd11, 12'hff9);
  endtask

  task automatic test_branches();
    logic [2:0] codes [6];
    logic [12:0] off;
    codes = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    run_op_imm(F3_ADDI, 5'd5, 5'd0, 12'hffb);
    run_op_imm(F3_ADDI, 5'd6, 5'd0, 12'h003);
    run_op_imm(F3_ADDI, 5'd7, 5'd0, 12'hffb);
    for (int k = 0; k < 6; k++) begin
      off = 13'(($urandom_range(31, 0) - 16) * 4);
      run_branch(codes[k], 5'd5, 5'd7, off);
      run_branch(codes[k], 5'd5, 5'd6, off);
      run_branch(codes[k], 5'd6, 5'd5, off);
    end
  endtask

  task automatic test_back_to_back_illegal();
    idle(3);
    run_op_imm(F3_ADDI, 5'd3, 5'd0, 12'h05a);
    run_illegal({20'habcde, 5'd3, 5'b01101, 2'b11}, "lui");
    run_illegal(enc_i(OPC_OP_IMM, 3'b001, 5'd3, 5'd3, 12'h004), "slli");
    run_illegal({7'h00, 5'd6, 5'd5, 3'b010, 5'd3, OPC_BRANCH, 2'b11}, "branch funct3");
    run_illegal(32'h0000_4185, "compressed");
    run_op_imm(F3_ADDI, 5'd4, 5'd3, 12'h000);
    idle(2);
  endtask

  initial begin
    void'($urandom(32'h8112_d79c));
    clock      = 1'b0;
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    checks     = 0;
    errors     = 0;
    model_pc   = RESET_PC;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    repeat (RESET_CYCLES) @(negedge clock);
    rst = 1'b0;
    test_reset();
    test_op_imm();
    test_auipc();
    test_jumps();
    test_branches();
    test_back_to_back_illegal();
    $display("Done: %0d checks, %0d mismatches, %0d assertion failures", checks, errors,
             core_top_i.core_top_assert_i.fail_count);
    if (errors == 0 && core_top_i.core_top_assert_i.fail_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog.
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish within %0d ns.", TIMEOUT_NS);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- tb/core_top_assert.sv
// Concurrent checks on core_top strobe timing, PC alignment and retire write enable; bound below.
module core_top_assert (
  input logic            clock,
  input logic            rst,
  input logic            inst_valid,
  input rv_pkg::word_t   pc,
  input logic            retire_valid,
  input rv_pkg::retire_t retire
);
  timeunit 1ns;
  timeprecision 1ps;

  // Number of failed assertions.
  int fail_count = 0;

  retire_follows_strobe: assert property (@(posedge clock) disable iff (rst)
    retire_valid == $past(inst_valid))
  else begin
    fail_count++;
    $error("retire_valid does not follow inst_valid by one cycle");
  end

  pc_aligned: assert property (@(posedge clock) disable iff (rst) pc[1:0] == 2'b00)
  else begin
    fail_count++;
    $error("pc is not 4-byte aligned");
  end

  // No write for illegal instructions or x0.
  retire_we_legal: assert property (@(posedge clock) disable iff (rst)
    retire_valid |-> !(retire.rd_we && (retire.illegal || retire.rd == 5'd0)))
  else begin
    fail_count++;
    $error("retire record has rd_we set for an illegal instruction or x0");
  end

endmodule

bind core_top core_top_assert core_top_assert_i (
  .clock        (clock),
  .rst          (rst),
  .inst_valid   (inst_valid),
  .pc           (pc),
  .retire_valid (retire_valid),
  .retire       (retire)
);

//--- source/core_top.sv
// Top of the RV64I execute slice; takes one strobed instruction at a time and retires it.
module core_top #(
  parameter rv_pkg::word_t RESET_PC = 64'h8000_0000
) (
  input  logic            clock,
  input  logic            rst,
  input  logic            inst_valid,
  input  rv_pkg::inst_t   inst,
  output rv_pkg::word_t   pc,
  output logic            retire_valid,
  output rv_pkg::retire_t retire
);
  import rv_pkg::*;

  decoded_t dec;
  opcode_e  opcode;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    op1;
  word_t    op2;
  word_t    t1;
  word_t    pc_plus4;
  word_t    pc_plus_imm;
  word_t    rd_data;
  word_t    pc_jmpaddr;
  word_t    pc_next;
  logic     pc_jmp;
  logic     wb_en;
  logic     rd_we;

  inst_decode inst_decode_i (
    .inst (inst),
    .dec  (dec)
  );

  reg_file reg_file_i (
    .clock    (clock),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rd_we),
    .rd       (dec.rd),
    .rd_data  (rd_data)
  );

  assign opcode      = opcode_e'(inst[6:2]);
  assign pc_plus4    = pc + word_t'(4);
  assign pc_plus_imm = pc + dec.imm;

  // Operand routing per instruction class.
  always_comb begin
    op1 = rs1_data;
    op2 = dec.imm;
    t1  = pc_plus4;
    case (opcode)
      OPC_AUIPC: op1 = pc;
      OPC_JAL: begin
        op1 = pc_plus4;
        op2 = pc_plus_imm;
      end
      OPC_BRANCH: begin
        op2 = rs2_data;
        t1  = pc_plus_imm;
      end
      default: ;
    endcase
  end

  exe_stage exe_stage_i (
    .op         (dec.op),
    .funct3     (dec.funct3),
    .op1        (op1),
    .op2        (op2),
    .t1         (t1),
    .rd_data    (rd_data),
    .pc_jmp     (pc_jmp),
    .pc_jmpaddr (pc_jmpaddr)
  );

  pc_unit #(
    .RESET_PC (RESET_PC)
  ) pc_unit_i (
    .clock      (clock),
    .rst        (rst),
    .inst_valid (inst_valid),
    .pc_jmp     (pc_jmp),
    .pc_jmpaddr (pc_jmpaddr),
    .pc         (pc),
    .pc_next    (pc_next)
  );

  // No write for illegal instructions or x0.
  assign wb_en = dec.writes_rd && !dec.illegal && (dec.rd != '0);
  assign rd_we = inst_valid && wb_en;

  always_ff @(posedge clock) begin
    if (rst) begin
      retire_valid <= 1'b0;
      retire       <= '0;
    end else begin
      retire_valid <= inst_valid;
      if (inst_valid) begin
        retire.pc      <= pc;
        retire.next_pc <= pc_next;
        retire.rd      <= dec.rd;
        retire.rd_data <= rd_data;
        retire.rd_we   <= wb_en;
        retire.jumped  <= pc_jmp;
        retire.illegal <= dec.illegal;
      end
    end
  end

endmodule

//--- source/pc_unit.sv
// Program counter register; starts at the reset vector and steps on each instruction strobe.
module pc_unit #(
  parameter rv_pkg::word_t RESET_PC = 64'h8000_0000
) (
  input  logic          clock,
  input  logic          rst,
  input  logic          inst_valid,
  input  logic          pc_jmp,
  input  rv_pkg::word_t pc_jmpaddr,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t pc_next
);
  import rv_pkg::*;

  // Taken jump, else the sequential address.
  assign pc_next = pc_jmp ? pc_jmpaddr : pc + word_t'(4);

  always_ff @(posedge clock) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (inst_valid) begin
      pc <= pc_next;
    end
  end

endmodule

//--- source/exe_stage.sv
// Combinational execute stage; produces the write-back value, jump decision and jump target.
module exe_stage (
  input  rv_pkg::exe_op_e op,
  input  logic [2:0]      funct3,
  input  rv_pkg::word_t   op1,
  input  rv_pkg::word_t   op2,
  input  rv_pkg::word_t   t1,
  output rv_pkg::word_t   rd_data,
  output logic            pc_jmp,
  output rv_pkg::word_t   pc_jmpaddr
);
  import rv_pkg::*;

  word_t sum;
  logic  eq;
  logic  lt_s;
  logic  lt_u;
  logic  br_taken;

  assign sum  = op1 + op2;
  assign eq   = (op1 == op2);
  assign lt_s = ($signed(op1) < $signed(op2));
  assign lt_u = (op1 < op2);

  always_comb begin
    case (op)
      EXE_ADD:  rd_data = sum;
      EXE_SLT:  rd_data = word_t'(lt_s);
      EXE_SLTU: rd_data = word_t'(lt_u);
      EXE_JAL:  rd_data = op1;
      EXE_JALR: rd_data = t1;
      default:  rd_data = '0;
    endcase
  end

  // Branch compare.
  always_comb begin
    case (funct3)
      F3_BEQ:  br_taken = eq;
      F3_BNE:  br_taken = !eq;
      F3_BLT:  br_taken = lt_s;
      F3_BGE:  br_taken = !lt_s;
      F3_BLTU: br_taken = lt_u;
      F3_BGEU: br_taken = !lt_u;
      default: br_taken = 1'b0;
    endcase
  end

  always_comb begin
    case (op)
      EXE_JAL,
      EXE_JALR:   pc_jmp = 1'b1;
      EXE_BRANCH: pc_jmp = br_taken;
      default:    pc_jmp = 1'b0;
    endcase
  end

  always_comb begin
    case (op)
      EXE_JAL:    pc_jmpaddr = op2;
      // Bit 0 of the JALR target is dropped.
      EXE_JALR:   pc_jmpaddr = {sum[XLEN-1:1], 1'b0};
      EXE_BRANCH: pc_jmpaddr = t1;
      default:    pc_jmpaddr = '0;
    endcase
  end

endmodule

//--- source/reg_file.sv
// Integer register file with two combinational read ports and one clocked write port.
module reg_file (
  input  logic             clock,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  input  logic             we,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    rd_data
);
  import rv_pkg::*;

  // x0 has no storage.
  word_t regs [1:31];

  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- source/inst_decode.sv
// Combinational RV64I decoder; splits an instruction word into indices, immediate and controls.
module inst_decode (
  input  rv_pkg::inst_t    inst,
  output rv_pkg::decoded_t dec
);
  import rv_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  word_t      imm_i;
  word_t      imm_u;
  word_t      imm_j;
  word_t      imm_b;

  assign opcode = opcode_e'(inst[6:2]);
  assign funct3 = inst[14:12];

  // Immediates, all sign-extended from bit 31.
  assign imm_i = {{(XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_u = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_b = {{(XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

  always_comb begin
    dec           = '0;
    dec.op        = EXE_NONE;
    dec.funct3    = funct3;
    dec.rs1       = inst[19:15];
    dec.rs2       = inst[24:20];
    dec.rd        = inst[11:7];
    dec.imm       = imm_i;
    dec.writes_rd = 1'b0;
    dec.illegal   = 1'b0;

    // Compressed encodings are not supported.
    if (inst[1:0] != 2'b11) begin
      dec.illegal = 1'b1;
    end else begin
      case (opcode)
        OPC_AUIPC: begin
          dec.op        = EXE_ADD;
          dec.imm       = imm_u;
          dec.writes_rd = 1'b1;
        end
        OPC_OP_IMM: begin
          dec.writes_rd = 1'b1;
          case (funct3)
            F3_ADDI:  dec.op = EXE_ADD;
            F3_SLTI:  dec.op = EXE_SLT;
            F3_SLTIU: dec.op = EXE_SLTU;
            default: begin
              dec.writes_rd = 1'b0;
              dec.illegal   = 1'b1;
            end
          endcase
        end
        OPC_JAL: begin
          dec.op        = EXE_JAL;
          dec.imm       = imm_j;
          dec.writes_rd = 1'b1;
        end
        OPC_JALR: begin
          if (funct3 == 3'b000) begin
            dec.op        = EXE_JALR;
            dec.writes_rd = 1'b1;
          end else begin
            dec.illegal = 1'b1;
          end
        end
        OPC_BRANCH: begin
          dec.imm = imm_b;
          case (funct3)
            F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU: begin
              dec.op = EXE_BRANCH;
            end
            default: dec.illegal = 1'b1;
          endcase
        end
        default: dec.illegal = 1'b1;
      endcase
    end
  end

endmodule

//--- source/rv_pkg.sv
// Shared widths, RV64I encodings and the decode and retire structs; import into each RTL module.
package rv_pkg;

  localparam int XLEN = 64;

  typedef logic [4:0]      reg_idx_t;
  typedef logic [XLEN-1:0] word_t;
  typedef logic [31:0]     inst_t;

  // Major opcode, instruction bits 6 to 2.
  typedef enum logic [4:0] {
    OPC_OP_IMM = 5'b00100,
    OPC_AUIPC  = 5'b00101,
    OPC_BRANCH = 5'b11000,
    OPC_JALR   = 5'b11001,
    OPC_JAL    = 5'b11011
  } opcode_e;

  // OP_IMM funct3.
  localparam logic [2:0] F3_ADDI  = 3'b000;
  localparam logic [2:0] F3_SLTI  = 3'b010;
  localparam logic [2:0] F3_SLTIU = 3'b011;

  // BRANCH funct3.
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Operation carried out by the execute stage.
  typedef enum logic [2:0] {
    EXE_NONE   = 3'd0,
    EXE_ADD    = 3'd1,
    EXE_SLT    = 3'd2,
    EXE_SLTU   = 3'd3,
    EXE_JAL    = 3'd4,
    EXE_JALR   = 3'd5,
    EXE_BRANCH = 3'd6
  } exe_op_e;

  typedef struct packed {
    exe_op_e    op;
    logic [2:0] funct3;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    word_t      imm;
    logic       writes_rd;
    logic       illegal;
  } decoded_t;

  // One record per retired instruction.
  typedef struct packed {
    word_t    pc;
    word_t    next_pc;
    reg_idx_t rd;
    word_t    rd_data;
    logic     rd_we;
    logic     jumped;
    logic     illegal;
  } retire_t;

endpackage
